/* Bender.yml */
package:
  name: execute_stage

sources:
  - include_dirs:
      - source
    files:
      - source/exec_pkg.sv
      - source/alu_decoder.sv
      - source/alu.sv
      - source/muldiv_unit.sv
      - source/execute_stage.sv
  - target: test
    include_dirs:
      - source
      - verification
    files:
      - verification/execute_stage_tb.sv

/* source/alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module alu (
	input wire logic [`EXEC_XLEN-1:0] a,
	input wire logic [`EXEC_XLEN-1:0] b,
	input wire logic [`EXEC_XLEN-1:0] pc,
	input wire logic [`EXEC_REG_W-1:0] sa,
	input wire exec_pkg::alu_op_e op,
	output logic [`EXEC_XLEN-1:0] result,
	output logic overflow
);
	import exec_pkg::*;

	localparam int MSB = `EXEC_XLEN - 1;

	logic [`EXEC_XLEN-1:0] sum;
	logic [`EXEC_XLEN-1:0] diff;
	logic [`EXEC_REG_W-1:0] amt;

	assign sum = a + b;
	assign diff = a - b;
	// variable shifts take the amount from rs
	assign amt = a[`EXEC_REG_W-1:0];

	always_comb begin
		result = '0;
		overflow = 1'b0;
		case (op)
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_ADD: begin
				result = sum;
				overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			end
			ALU_SUB: begin
				result = diff;
				overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			ALU_ADDU: result = sum;
			ALU_SUBU: result = diff;
			ALU_SLT: result = {{MSB{1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU: result = {{MSB{1'b0}}, a < b};
			ALU_SLL_SA: result = b << sa;
			ALU_SRL_SA: result = b >> sa;
			ALU_SRA_SA: result = $signed(b) >>> sa;
			ALU_SLL: result = b << amt;
			ALU_SRL: result = b >> amt;
			ALU_SRA: result = $signed(b) >>> amt;
			// return address skips the delay slot
			ALU_PC_PLUS8: result = pc + `EXEC_XLEN'(8);
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/alu_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_decoder (
	input wire logic [31:0] instr,
	output exec_pkg::ex_ctrl_t ctrl
);
	import exec_pkg::*;

	opcode_e opcode;
	funct_e funct;
	regimm_e rt;
	alu_op_e op;
	logic imm;
	logic store;

	assign opcode = opcode_e'(instr[31:26]);
	assign rt = regimm_e'(instr[20:16]);
	assign funct = funct_e'(instr[5:0]);

	always_comb begin
		op = ALU_NOP;
		imm = 1'b0;
		store = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_AND: op = ALU_AND;
					FN_OR: op = ALU_OR;
					FN_XOR: op = ALU_XOR;
					FN_NOR: op = ALU_NOR;
					FN_ADD: op = ALU_ADD;
					FN_SUB: op = ALU_SUB;
					FN_ADDU: op = ALU_ADDU;
					FN_SUBU: op = ALU_SUBU;
					FN_SLT: op = ALU_SLT;
					FN_SLTU: op = ALU_SLTU;
					FN_MULT: op = ALU_MULT;
					FN_MULTU: op = ALU_MULTU;
					FN_DIV: op = ALU_DIV;
					FN_DIVU: op = ALU_DIVU;
					FN_SLL: op = ALU_SLL_SA;
					FN_SRL: op = ALU_SRL_SA;
					FN_SRA: op = ALU_SRA_SA;
					FN_SLLV: op = ALU_SLL;
					FN_SRLV: op = ALU_SRL;
					FN_SRAV: op = ALU_SRA;
					FN_MFHI: op = ALU_MFHI;
					FN_MFLO: op = ALU_MFLO;
					FN_MTHI: op = ALU_MTHI;
					FN_MTLO: op = ALU_MTLO;
					FN_JR: op = ALU_NOP;
					FN_JALR: op = ALU_PC_PLUS8;
					default: op = ALU_ADDU;
				endcase
			end
			OP_ADDI: op = ALU_ADD;
			OP_ADDIU: op = ALU_ADDU;
			OP_SLTI: op = ALU_SLT;
			OP_SLTIU: op = ALU_SLTU;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: op = ALU_ADD;
			OP_SB, OP_SH, OP_SW: begin
				op = ALU_ADD;
				store = 1'b1;
			end
			OP_REGIMM: begin
				if (rt == RI_BLTZAL || rt == RI_BGEZAL)
					op = ALU_PC_PLUS8;
				else
					op = ALU_NOP;
			end
			OP_JAL: op = ALU_PC_PLUS8;
			default: op = ALU_NOP;
		endcase

		// immediate operand for every I-type and memory opcode
		case (opcode)
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: imm = 1'b1;
			default: imm = 1'b0;
		endcase
	end

	always_comb begin
		ctrl.alu_op = op;
		ctrl.src_imm = imm;
		case (op)
			ALU_NOP, ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU, ALU_MTHI, ALU_MTLO:
				ctrl.wr_en = 1'b0;
			default: ctrl.wr_en = !store;
		endcase
	end

endmodule

`default_nettype wire

/* source/exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// datapath width
`define EXEC_XLEN 32

// register index and shift amount width
`define EXEC_REG_W 5

// restoring divider produces one quotient bit per step
`define EXEC_DIV_STEPS `EXEC_XLEN

`endif

/* source/exec_pkg.sv */
`default_nettype none

`include "exec_macros.svh"

package exec_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000, OP_REGIMM = 6'b000001, OP_J = 6'b000010, OP_JAL = 6'b000011,
		OP_BEQ = 6'b000100, OP_BNE = 6'b000101, OP_BLEZ = 6'b000110, OP_BGTZ = 6'b000111,
		OP_ADDI = 6'b001000, OP_ADDIU = 6'b001001, OP_SLTI = 6'b001010,
		OP_SLTIU = 6'b001011,
		OP_LB = 6'b100000, OP_LH = 6'b100001, OP_LW = 6'b100011, OP_LBU = 6'b100100,
		OP_LHU = 6'b100101, OP_SB = 6'b101000, OP_SH = 6'b101001, OP_SW = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL = 6'b000000, FN_SRL = 6'b000010, FN_SRA = 6'b000011, FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110, FN_SRAV = 6'b000111, FN_JR = 6'b001000, FN_JALR = 6'b001001,
		FN_MFHI = 6'b010000, FN_MTHI = 6'b010001, FN_MFLO = 6'b010010,
		FN_MTLO = 6'b010011,
		FN_MULT = 6'b011000, FN_MULTU = 6'b011001, FN_DIV = 6'b011010,
		FN_DIVU = 6'b011011,
		FN_ADD = 6'b100000, FN_ADDU = 6'b100001, FN_SUB = 6'b100010, FN_SUBU = 6'b100011,
		FN_AND = 6'b100100, FN_OR = 6'b100101, FN_XOR = 6'b100110, FN_NOR = 6'b100111,
		FN_SLT = 6'b101010, FN_SLTU = 6'b101011
	} funct_e;

	// rt field of the regimm group
	typedef enum logic [4:0] {
		RI_BLTZ = 5'b00000, RI_BGEZ = 5'b00001, RI_BLTZAL = 5'b10000, RI_BGEZAL = 5'b10001
	} regimm_e;

	typedef enum logic [4:0] {
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_ADD, ALU_SUB, ALU_ADDU, ALU_SUBU, ALU_SLT, ALU_SLTU,
		ALU_SLL_SA, ALU_SRL_SA, ALU_SRA_SA, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
		ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
		ALU_PC_PLUS8, ALU_NOP
	} alu_op_e;

	typedef struct packed {
		logic [31:0] instr;
		logic [`EXEC_XLEN-1:0] rs_value;
		logic [`EXEC_XLEN-1:0] rt_value;
		logic [`EXEC_XLEN-1:0] pc;
	} ex_req_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic src_imm;
		logic wr_en;
	} ex_ctrl_t;

	typedef struct packed {
		logic [`EXEC_XLEN-1:0] result;
		logic wr_en;
		logic overflow;
		logic [`EXEC_XLEN-1:0] pc;
	} ex_resp_t;

endpackage

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module execute_stage (
	input wire logic clk,
	input wire logic rst,
	input wire logic in_valid,
	input wire exec_pkg::ex_req_t in_req,
	output logic in_ready,
	output logic out_valid,
	output exec_pkg::ex_resp_t out_resp,
	input wire logic out_ready
);
	import exec_pkg::*;

	ex_ctrl_t ctrl;
	logic [`EXEC_XLEN-1:0] imm_ext;
	logic [`EXEC_XLEN-1:0] op_b;
	logic [`EXEC_XLEN-1:0] alu_result;
	logic alu_overflow;
	logic [`EXEC_XLEN-1:0] hi;
	logic [`EXEC_XLEN-1:0] lo;
	logic busy;
	logic accept;
	logic is_div;
	logic div_pending;
	logic div_done;
	logic [`EXEC_XLEN-1:0] div_pc;
	ex_resp_t resp_next;
	ex_resp_t div_resp;

	alu_decoder u_decoder (
		.instr(in_req.instr),
		.ctrl(ctrl)
	);

	assign imm_ext = {{(`EXEC_XLEN-16){in_req.instr[15]}}, in_req.instr[15:0]};
	assign op_b = ctrl.src_imm ? imm_ext : in_req.rt_value;

	alu u_alu (
		.a(in_req.rs_value),
		.b(op_b),
		.pc(in_req.pc),
		.sa(in_req.instr[10:6]),
		.op(ctrl.alu_op),
		.result(alu_result),
		.overflow(alu_overflow)
	);

	muldiv_unit u_muldiv (
		.clk(clk),
		.rst(rst),
		.start(accept),
		.op(ctrl.alu_op),
		.a(in_req.rs_value),
		.b(in_req.rt_value),
		.busy(busy),
		.hi(hi),
		.lo(lo)
	);

	// stall while a divide is running or its response is not yet out
	assign in_ready = (!out_valid || out_ready) && !busy && !div_pending;
	assign accept = in_valid && in_ready;
	assign is_div = (ctrl.alu_op == ALU_DIV) || (ctrl.alu_op == ALU_DIVU);
	assign div_done = div_pending && !busy;

	always_comb begin
		case (ctrl.alu_op)
			ALU_MFHI: resp_next.result = hi;
			ALU_MFLO: resp_next.result = lo;
			default: resp_next.result = alu_result;
		endcase
		// overflowing add/sub must not write back
		resp_next.wr_en = ctrl.wr_en && !alu_overflow;
		resp_next.overflow = alu_overflow;
		resp_next.pc = in_req.pc;
	end

	assign div_resp = '{result: '0, wr_en: 1'b0, overflow: 1'b0, pc: div_pc};

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			div_pending <= 1'b0;
		end else begin
			if (accept && is_div)
				div_pending <= 1'b1;
			else if (div_done)
				div_pending <= 1'b0;

			if ((accept && !is_div) || div_done)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !is_div)
			out_resp <= resp_next;
		else if (div_done)
			out_resp <= div_resp;

		if (accept && is_div)
			div_pc <= in_req.pc;
	end

endmodule

`default_nettype wire

/* source/muldiv_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module muldiv_unit (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire exec_pkg::alu_op_e op,
	input wire logic [`EXEC_XLEN-1:0] a,
	input wire logic [`EXEC_XLEN-1:0] b,
	output logic busy,
	output logic [`EXEC_XLEN-1:0] hi,
	output logic [`EXEC_XLEN-1:0] lo
);
	import exec_pkg::*;

	localparam int MSB = `EXEC_XLEN - 1;
	localparam int CNT_W = $clog2(`EXEC_DIV_STEPS);

	logic signed [2*`EXEC_XLEN-1:0] prod_s;
	logic [2*`EXEC_XLEN-1:0] prod_u;
	logic is_sdiv;
	logic [`EXEC_XLEN-1:0] a_mag;
	logic [`EXEC_XLEN-1:0] b_mag;
	logic [`EXEC_XLEN-1:0] rem;
	logic [`EXEC_XLEN-1:0] quo;
	logic [`EXEC_XLEN-1:0] dvsr;
	logic neg_q;
	logic neg_r;
	logic div_zero;
	logic [CNT_W-1:0] count;
	logic [`EXEC_XLEN:0] partial;
	logic [`EXEC_XLEN:0] trial;
	logic [`EXEC_XLEN-1:0] rem_next;
	logic [`EXEC_XLEN-1:0] quo_next;
	logic last_step;

	assign prod_s = $signed(a) * $signed(b);
	assign prod_u = a * b;

	assign is_sdiv = (op == ALU_DIV);
	assign a_mag = (is_sdiv && a[MSB]) ? -a : a;
	assign b_mag = (is_sdiv && b[MSB]) ? -b : b;

	// one restoring step, next dividend bit shifted into the remainder
	assign partial = {rem, quo[MSB]};
	assign trial = partial - {1'b0, dvsr};
	assign rem_next = trial[`EXEC_XLEN] ? partial[MSB:0] : trial[MSB:0];
	assign quo_next = {quo[MSB-1:0], ~trial[`EXEC_XLEN]};
	assign last_step = (count == CNT_W'(`EXEC_DIV_STEPS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			count <= '0;
			hi <= '0;
			lo <= '0;
		end else if (busy) begin
			count <= count + 1'b1;
			if (last_step) begin
				busy <= 1'b0;
				// divide by zero leaves HI/LO alone
				if (!div_zero) begin
					hi <= neg_r ? -rem_next : rem_next;
					lo <= neg_q ? -quo_next : quo_next;
				end
			end
		end else if (start) begin
			case (op)
				ALU_MULT: {hi, lo} <= prod_s;
				ALU_MULTU: {hi, lo} <= prod_u;
				ALU_MTHI: hi <= a;
				ALU_MTLO: lo <= a;
				ALU_DIV, ALU_DIVU: begin
					busy <= 1'b1;
					count <= '0;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start) begin
			rem <= '0;
			quo <= a_mag;
			dvsr <= b_mag;
			neg_q <= is_sdiv && (a[MSB] ^ b[MSB]);
			neg_r <= is_sdiv && a[MSB];
			div_zero <= (b == '0);
		end else if (busy) begin
			rem <= rem_next;
			quo <= quo_next;
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
+incdir+verification
source/exec_pkg.sv
source/alu_decoder.sv
source/alu.sv
source/muldiv_unit.sv
source/execute_stage.sv
verification/execute_stage_tb.sv

/* verification/exec_ref.svh */
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// HI/LO as the instruction stream should see them
logic [31:0] model_hi;
logic [31:0] model_lo;

// a 33-bit sign-extended sum that does not fit in 32 signed bits
function automatic logic signed_ovf(input logic [32:0] wide);
	return wide[32] != wide[31];
endfunction

function automatic void model_divide(input logic [31:0] a, input logic [31:0] b,
		input logic sgn);
	logic [31:0] am;
	logic [31:0] bm;
	// divide by zero keeps HI/LO
	if (b == '0)
		return;
	am = (sgn && a[31]) ? -a : a;
	bm = (sgn && b[31]) ? -b : b;
	// quotient truncates toward zero, remainder follows the dividend
	model_lo = (sgn && (a[31] ^ b[31])) ? -(am / bm) : am / bm;
	model_hi = (sgn && a[31]) ? -(am % bm) : am % bm;
endfunction

function automatic ex_resp_t predict(input ex_req_t req);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [4:0] sa;
	ex_resp_t rsp;
	a = req.rs_value;
	b = req.rt_value;
	imm = {{16{req.instr[15]}}, req.instr[15:0]};
	sa = req.instr[10:6];
	rsp = '{result: '0, wr_en: 1'b1, overflow: 1'b0, pc: req.pc};
	case (req.instr[31:26])
		6'h00: begin
			case (req.instr[5:0])
				6'h00: rsp.result = b << sa;
				6'h02: rsp.result = b >> sa;
				6'h03: rsp.result = $signed(b) >>> sa;
				6'h04: rsp.result = b << a[4:0];
				6'h06: rsp.result = b >> a[4:0];
				6'h07: rsp.result = $signed(b) >>> a[4:0];
				6'h08: rsp.result = '0;
				6'h09: rsp.result = req.pc + 32'd8;
				6'h10: rsp.result = model_hi;
				6'h11: model_hi = a;
				6'h12: rsp.result = model_lo;
				6'h13: model_lo = a;
				6'h18: {model_hi, model_lo} = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
				6'h19: {model_hi, model_lo} = {32'd0, a} * {32'd0, b};
				6'h1a: model_divide(a, b, 1'b1);
				6'h1b: model_divide(a, b, 1'b0);
				6'h20: begin
					rsp.result = a + b;
					rsp.overflow = signed_ovf({a[31], a} + {b[31], b});
				end
				6'h22: begin
					rsp.result = a - b;
					rsp.overflow = signed_ovf({a[31], a} - {b[31], b});
				end
				6'h23: rsp.result = a - b;
				6'h24: rsp.result = a & b;
				6'h25: rsp.result = a | b;
				6'h26: rsp.result = a ^ b;
				6'h27: rsp.result = ~(a | b);
				6'h2a: rsp.result = {31'd0, $signed(a) < $signed(b)};
				6'h2b: rsp.result = {31'd0, a < b};
				// any other funct adds without trapping
				default: rsp.result = a + b;
			endcase
			rsp.wr_en = !(req.instr[5:0] inside {6'h08, 6'h11, 6'h13, [6'h18:6'h1b]});
		end
		// addi and every load and store form rs + imm
		6'h08, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b: begin
			rsp.result = a + imm;
			rsp.overflow = signed_ovf({a[31], a} + {imm[31], imm});
			rsp.wr_en = (req.instr[31:29] != 3'b101);
		end
		6'h09: rsp.result = a + imm;
		6'h0a: rsp.result = {31'd0, $signed(a) < $signed(imm)};
		6'h0b: rsp.result = {31'd0, a < imm};
		6'h03: rsp.result = req.pc + 32'd8;
		6'h01: begin
			rsp.wr_en = req.instr[20:16] inside {5'h10, 5'h11};
			rsp.result = rsp.wr_en ? req.pc + 32'd8 : '0;
		end
		default: rsp.wr_en = 1'b0;
	endcase
	if (rsp.overflow)
		rsp.wr_en = 1'b0;
	return rsp;
endfunction

`endif

/* verification/execute_stage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module execute_stage_tb;
	import exec_pkg::*;

	`include "exec_ref.svh"

	localparam int RESET_CYCLES = 16;
	localparam int N_ARITH = 60;
	localparam int N_SHIFT = 36;
	localparam int N_IMM = 43;
	localparam int N_MULDIV = 72;
	localparam int N_MOVE = 16;
	localparam int N_BRANCH = 30;
	localparam int N_REQ = N_ARITH + N_SHIFT + N_IMM + N_MULDIV + N_MOVE + N_BRANCH;
	localparam int CYCLE_LIMIT = N_REQ * (`EXEC_DIV_STEPS + 4) + RESET_CYCLES;

	localparam funct_e ARITH_FN[10] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_ADD, FN_SUB,
		FN_ADDU, FN_SUBU, FN_SLT, FN_SLTU};
	localparam funct_e SHIFT_FN[6] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
	localparam funct_e MULDIV_FN[4] = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU};
	localparam opcode_e IMM_OP[10] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LB, OP_LW,
		OP_LHU, OP_SB, OP_SH, OP_SW};

	logic clk;
	logic rst;
	logic in_valid;
	ex_req_t in_req;
	logic in_ready;
	logic out_valid;
	ex_resp_t out_resp;
	logic out_ready;
	logic bp_on;
	ex_resp_t expected[$];
	int cycles;
	int div_left;

	execute_stage DUT (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_req(in_req),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_resp(out_resp),
		.out_ready(out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on failure");
	endtask

	task automatic flag_problem(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	function automatic logic is_divide(input logic [31:0] instr);
		return instr[31:26] == 6'h00 && instr[5:0] inside {6'h1a, 6'h1b};
	endfunction

	function automatic logic [31:0] rtype(input logic [5:0] funct, input logic [4:0] sa);
		return {6'h00, 5'($urandom), 5'($urandom), 5'($urandom), sa, funct};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] opcode, input logic [4:0] rt,
			input logic [15:0] imm);
		return {opcode, 5'($urandom), rt, imm};
	endfunction

	task automatic send(input logic [31:0] instr, input logic [31:0] rs,
			input logic [31:0] rt);
		in_valid <= 1'b1;
		in_req <= '{instr: instr, rs_value: rs, rt_value: rt, pc: $urandom & 32'hffff_fffc};
		do
			@(posedge clk);
		while (!in_ready);
		in_valid <= 1'b0;
	endtask

	task automatic send_with_random_operands(input logic [31:0] instr);
		send(instr, $urandom, $urandom);
	endtask

	task automatic drive_out_ready();
		forever begin
			@(posedge clk);
			out_ready <= !bp_on || ($urandom % 3 != 0);
		end
	endtask

	// hung run guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("run hung: no end after %0d cycles", cycles);
			abort_run();
		end
	end

	// responses are checked before new requests are queued
	always @(posedge clk) begin
		if (!rst && out_valid && out_ready) begin
			assert (expected.size() != 0)
			else flag_problem("response without a pending request");
			assert (out_resp == expected[0])
			else flag_problem($sformatf("resp %h/%b/%b/%h, expected %h/%b/%b/%h",
				out_resp.result, out_resp.wr_en, out_resp.overflow, out_resp.pc,
				expected[0].result, expected[0].wr_en, expected[0].overflow, expected[0].pc));
			void'(expected.pop_front());
		end
		if (!rst && in_valid && in_ready)
			expected.push_back(predict(in_req));
	end

	// divide closes the stage until its response is out
	always @(posedge clk) begin
		if (div_left == 1) begin
			assert (out_valid)
			else flag_problem("divide response not valid on time");
		end else if (div_left > 1) begin
			assert (!in_ready && !out_valid)
			else flag_problem("stage open or responding during a divide");
		end
		if (div_left > 0)
			div_left <= div_left - 1;
		if (!rst && in_valid && in_ready && is_divide(in_req.instr))
			div_left <= `EXEC_DIV_STEPS + 2;
	end

	assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_resp))
	else flag_problem("out_resp changed while waiting");

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0] amt;
		void'($urandom(32'he807_e5c0));
		rst = 1'b1;
		in_valid = 1'b0;
		in_req = '0;
		out_ready = 1'b1;
		bp_on = 1'b0;
		cycles = 0;
		div_left = 0;
		model_hi = '0;
		model_lo = '0;
		fork
			drive_out_ready();
		join_none
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		assert (!out_valid && in_ready)
		else flag_problem("stage not idle after reset");

		// back to back without stalls
		repeat (N_ARITH)
			send_with_random_operands(rtype(ARITH_FN[$urandom % 10], 5'($urandom)));
		bp_on <= 1'b1;

		// each shift with amounts 0, 31 and random
		for (int i = 0; i < N_SHIFT; i++) begin
			amt = (i % 3 == 0) ? 5'd0 : (i % 3 == 1) ? 5'd31 : 5'($urandom);
			send(rtype(SHIFT_FN[(i / 3) % 6], amt), {27'($urandom), amt}, $urandom);
		end

		repeat (N_IMM - 3)
			send_with_random_operands(itype(IMM_OP[$urandom % 10], 5'($urandom), 16'($urandom)));
		send(rtype(FN_ADD, 5'd0), 32'h7fff_ffff, 32'h0000_0001);
		send(rtype(FN_SUB, 5'd0), 32'h8000_0000, 32'h0000_0001);
		send(itype(OP_ADDI, 5'd0, 16'h0001), 32'h7fff_ffff, 32'h0);

		// divisor sign flips every four groups, a third of the groups divide by zero
		for (int i = 0; i < N_MULDIV / 3; i++) begin
			a = $urandom;
			b = $urandom >> ($urandom % 32);
			if ((i / 4) % 2 == 1)
				b = -b;
			if (i % 12 >= 8)
				b = '0;
			send(rtype(MULDIV_FN[i % 4], 5'd0), a, b);
			send_with_random_operands(rtype(FN_MFHI, 5'd0));
			send_with_random_operands(rtype(FN_MFLO, 5'd0));
		end

		repeat (N_MOVE / 4) begin
			send(rtype(FN_MTHI, 5'd0), $urandom, $urandom);
			send(rtype(FN_MTLO, 5'd0), $urandom, $urandom);
			send_with_random_operands(rtype(FN_MFHI, 5'd0));
			send_with_random_operands(rtype(FN_MFLO, 5'd0));
		end

		repeat (N_BRANCH / 15) begin
			send_with_random_operands(rtype(FN_JALR, 5'd0));
			send_with_random_operands(rtype(FN_JR, 5'd0));
			send_with_random_operands(itype(OP_JAL, 5'($urandom), 16'($urandom)));
			send_with_random_operands(itype(OP_J, 5'($urandom), 16'($urandom)));
			send_with_random_operands(itype(OP_REGIMM, RI_BLTZAL, 16'($urandom)));
			send_with_random_operands(itype(OP_REGIMM, RI_BGEZAL, 16'($urandom)));
			send_with_random_operands(itype(OP_REGIMM, RI_BLTZ, 16'($urandom)));
			send_with_random_operands(itype(OP_REGIMM, RI_BGEZ, 16'($urandom)));
			// rt code outside the regimm group
			send_with_random_operands(itype(OP_REGIMM, 5'h02, 16'($urandom)));
			send_with_random_operands(itype(OP_BEQ, 5'($urandom), 16'($urandom)));
			send_with_random_operands(itype(OP_BNE, 5'($urandom), 16'($urandom)));
			send_with_random_operands(itype(OP_BLEZ, 5'($urandom), 16'($urandom)));
			send_with_random_operands(itype(OP_BGTZ, 5'($urandom), 16'($urandom)));
			// unlisted functs
			send_with_random_operands(rtype(6'h05, 5'($urandom)));
			send_with_random_operands(rtype(6'h3f, 5'($urandom)));
		end

		bp_on <= 1'b0;
		// queue is looked at between edges so the last request is already in it
		@(negedge clk);
		for (int i = 0; i < `EXEC_DIV_STEPS + 8 && expected.size() != 0; i++)
			@(negedge clk);
		if (expected.size() == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("%0d expected responses never arrived", expected.size());
			abort_run();
		end
	end

endmodule

`default_nettype wire
